/* design/dataRam.sv */
`timescale 1ns/1ps
`default_nettype none

module dataRam (
    input  wire logic                             clk,
    input  wire logic [socPkg::ramAddrWidth-1:0]  addr,
    input  wire logic [socPkg::dataWidth-1:0]     wdata,
    input  wire logic                             wEn,
    input  wire logic                             rEn,
    output logic [socPkg::dataWidth-1:0]          rdata
);
    import socPkg::*;

    logic [dataWidth-1:0] mem [ramDepth];

    // ******************************************************************
    // Write port
    always_ff @(posedge clk) begin
        if (wEn) begin
            mem[addr] <= wdata;
        end
    end

    // Registered read, holds between reads
    // Same-cycle write to the read address returns the old byte
    always_ff @(posedge clk) begin
        if (rEn) begin
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

/* design/ioBlock.sv */
`timescale 1ns/1ps
`default_nettype none

module ioBlock (
    input  wire logic                          clk,
    input  wire logic                          arstN,
    input  wire logic [7:0]                    offset,
    input  wire logic [socPkg::dataWidth-1:0]  wdata,
    input  wire logic                          wEn,
    input  wire logic                          rEn,
    output logic [socPkg::dataWidth-1:0]       rdata,
    output logic [socPkg::dataWidth-1:0]       ioPins,
    output logic [socPkg::numMatch-1:0]        pwm,
    output logic                               irq
);
    import socPkg::*;

    timerCtrlT                           timerCtrl;
    logic [dataWidth-1:0]                timerTop;
    logic [dataWidth-1:0]                count;
    logic                                tick;
    logic                                topHit;
    logic [numMatch-1:0]                 matchHit;
    logic [numMatch-1:0]                 matchWEn;
    logic [numMatch-1:0][dataWidth-1:0]  compare;
    logic [irqBits-1:0]                  irqFlags;
    logic [irqBits-1:0]                  irqEnable;
    logic [dataWidth-1:0]                readMux;

    // ******************************************************************
    // Local registers: gpio, timer control and top
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ioPins    <= '0;
            timerCtrl <= '0;
            timerTop  <= '0;
        end else if (wEn) begin
            if (offset == regGpio)      ioPins    <= wdata;
            if (offset == regTimerCtrl) timerCtrl <= timerCtrlT'(wdata);
            if (offset == regTimerTop)  timerTop  <= wdata;
        end
    end

    timerCore uTimer (
        .clk       (clk),
        .arstN     (arstN),
        .ctrl      (timerCtrl),
        .top       (timerTop),
        .loadEn    (wEn && (offset == regTimerCount)),  // Also restarts prescaler
        .loadValue (wdata),
        .count     (count),
        .tick      (tick),
        .topHit    (topHit)
    );

    // ******************************************************************
    // Compare channels
    for (genvar i = 0; i < numMatch; i++) begin : gMatch
        assign matchWEn[i] = wEn && (offset == dataWidth'(regMatchBase + i));

        matchUnit uMatch (
            .clk      (clk),
            .arstN    (arstN),
            .wEn      (matchWEn[i]),
            .wdata    (wdata),
            .count    (count),
            .tick     (tick),
            .topHit   (topHit),
            .compare  (compare[i]),
            .matchHit (matchHit[i]),
            .pwm      (pwm[i])
        );
    end

    irqCollector uIrq (
        .clk       (clk),
        .arstN     (arstN),
        .hits      ({matchHit, topHit}),   // Bit 0 is the wrap
        .flagClrEn (wEn && (offset == regIrqFlags)),
        .enableWEn (wEn && (offset == regIrqEnable)),
        .wdata     (wdata),
        .flags     (irqFlags),
        .enable    (irqEnable),
        .irq       (irq)
    );

    // ******************************************************************
    // Read path
    always_comb begin
        readMux = '0;
        case (offset)
            regGpio:       readMux = ioPins;
            regTimerCtrl:  readMux = timerCtrl;
            regTimerTop:   readMux = timerTop;
            regTimerCount: readMux = count;
            regIrqFlags:   readMux = {{(dataWidth-irqBits){1'b0}}, irqFlags};
            regIrqEnable:  readMux = {{(dataWidth-irqBits){1'b0}}, irqEnable};
            default: begin
                for (int i = 0; i < numMatch; i++) begin
                    if (offset == dataWidth'(regMatchBase + i)) readMux = compare[i];
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rdata <= '0;
        end else if (rEn) begin
            rdata <= readMux;   // Held until the next read
        end
    end

endmodule

`default_nettype wire

/* design/irqCollector.sv */
`timescale 1ns/1ps
`default_nettype none

module irqCollector (
    input  wire logic                          clk,
    input  wire logic                          arstN,
    input  wire logic [socPkg::irqBits-1:0]    hits,
    input  wire logic                          flagClrEn,
    input  wire logic                          enableWEn,
    input  wire logic [socPkg::dataWidth-1:0]  wdata,
    output logic [socPkg::irqBits-1:0]         flags,
    output logic [socPkg::irqBits-1:0]         enable,
    output logic                               irq
);
    import socPkg::*;

    logic [irqBits-1:0] clrMask;

    // ******************************************************************
    // Sticky flags, write one to clear
    assign clrMask = flagClrEn ? wdata[irqBits-1:0] : '0;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            flags <= '0;
        end else begin
            flags <= (flags & ~clrMask) | hits;     // New hit beats the clear
        end
    end

    // Enable mask
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            enable <= '0;
        end else if (enableWEn) begin
            enable <= wdata[irqBits-1:0];
        end
    end

    assign irq = |(flags & enable);

    // Request can only come up after a hit or an enable write
    irqCause: assert property (@(posedge clk) disable iff (!arstN)
        $rose(irq) |-> $past(|hits) || $past(enableWEn))
        else $error("Interrupt raised with no hit and no enable write");

endmodule

`default_nettype wire

/* design/matchUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module matchUnit (
    input  wire logic                          clk,
    input  wire logic                          arstN,
    input  wire logic                          wEn,
    input  wire logic [socPkg::dataWidth-1:0]  wdata,
    input  wire logic [socPkg::dataWidth-1:0]  count,
    input  wire logic                          tick,
    input  wire logic                          topHit,
    output logic [socPkg::dataWidth-1:0]       compare,
    output logic                               matchHit,
    output logic                               pwm
);

    // ******************************************************************
    // Compare register
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            compare <= '0;
        end else if (wEn) begin
            compare <= wdata;
        end
    end

    // Only fires on the tick that moves the count past compare
    assign matchHit = tick && (count == compare);

    // PWM level, high from wrap to match
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pwm <= 1'b0;
        end else if (topHit) begin
            pwm <= 1'b1;    // Wrap wins when top equals compare
        end else if (matchHit) begin
            pwm <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* design/memMapDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module memMapDecoder (
    input  wire logic                          clk,
    input  wire logic                          arstN,
    input  wire socPkg::busReqT                req,
    output logic                               ramWEn,
    output logic                               ramREn,
    output logic                               ioWEn,
    output logic                               ioREn,
    input  wire logic [socPkg::dataWidth-1:0]  ramRdata,
    input  wire logic [socPkg::dataWidth-1:0]  ioRdata,
    output logic [socPkg::dataWidth-1:0]       rdata
);
    import socPkg::*;

    regionT region;
    regionT readRegion;     // Region of the last read

    function automatic logic inRange(input logic [addrWidth-1:0] addr,
                                     input logic [addrWidth-1:0] lo,
                                     input logic [addrWidth-1:0] hi);
        return (addr >= lo) && (addr <= hi);
    endfunction

    // ******************************************************************
    // Region decode
    always_comb begin
        if (inRange(req.addr, ramBase, ramLast)) begin
            region = regionRam;
        end else if (inRange(req.addr, ioBase, ioLast)) begin
            region = regionIo;
        end else if (inRange(req.addr, vidBase, vidLast)) begin
            region = regionVid;     // Writes dropped, reads give 0
        end else begin
            region = regionNone;
        end
    end

    assign ramWEn = req.wEn && (region == regionRam);
    assign ramREn = req.rEn && (region == regionRam);
    assign ioWEn  = req.wEn && (region == regionIo);
    assign ioREn  = req.rEn && (region == regionIo);

    // Targets register their data, so steer with the delayed region
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            readRegion <= regionNone;
        end else if (req.rEn) begin
            readRegion <= region;
        end
    end

    always_comb begin
        case (readRegion)
            regionRam: rdata = ramRdata;
            regionIo:  rdata = ioRdata;
            default:   rdata = '0;
        endcase
    end

    // Relies on the bus master never raising wEn and rEn together
    strobeExclusive: assert property (@(posedge clk) disable iff (!arstN)
        $onehot0({ramWEn, ramREn, ioWEn, ioREn}))
        else $error("More than one target strobe active");

endmodule

`default_nettype wire

/* design/socPkg.sv */
`default_nettype none

package socPkg;

    // ******************************************************************
    // Bus and memory sizes
    localparam int dataWidth    = 8;
    localparam int addrWidth    = 16;
    localparam int ramDepth     = 2048;
    localparam int ramAddrWidth = $clog2(ramDepth);

    // Compare channels, plus one flag for the timer wrap
    localparam int numMatch = 2;
    localparam int irqBits  = numMatch + 1;

    // ******************************************************************
    // Memory map
    localparam logic [addrWidth-1:0] ramBase = 16'h0000;
    localparam logic [addrWidth-1:0] ramLast = 16'h07FF;
    localparam logic [addrWidth-1:0] ioBase  = 16'h1000;
    localparam logic [addrWidth-1:0] ioLast  = 16'h10FF;
    localparam logic [addrWidth-1:0] vidBase = 16'h2000;   // Decoded, nothing behind it
    localparam logic [addrWidth-1:0] vidLast = 16'h2960;

    typedef enum logic [1:0] {
        regionRam,
        regionIo,
        regionVid,
        regionNone
    } regionT;

    // I/O register offsets, low address byte
    typedef enum logic [7:0] {
        regGpio       = 8'd0,
        regTimerCtrl  = 8'd1,
        regTimerTop   = 8'd2,
        regTimerCount = 8'd3,
        regIrqFlags   = 8'd4,
        regIrqEnable  = 8'd5,
        regMatchBase  = 8'd6    // Channel i at regMatchBase + i
    } ioRegT;

    // ******************************************************************
    // One CPU data bus request
    typedef struct packed {
        logic [addrWidth-1:0] addr;
        logic [dataWidth-1:0] wdata;
        logic                 wEn;
        logic                 rEn;
    } busReqT;

    // Timer control register layout
    typedef struct packed {
        logic       enable;
        logic [2:0] prescale;   // Tick every prescale + 1 cycles
        logic [3:0] reserved;
    } timerCtrlT;

endpackage

`default_nettype wire

/* design/socTop.sv */
`timescale 1ns/1ps
`default_nettype none

module socTop (
    input  wire logic                     clk,
    input  wire logic                     arstN,
    input  wire socPkg::busReqT           req,
    output logic [socPkg::dataWidth-1:0]  rdata,
    output logic [socPkg::dataWidth-1:0]  ioPins,
    output logic [socPkg::numMatch-1:0]   pwm,
    output logic                          irq
);
    import socPkg::*;

    logic                 ramWEn;
    logic                 ramREn;
    logic                 ioWEn;
    logic                 ioREn;
    logic [dataWidth-1:0] ramRdata;
    logic [dataWidth-1:0] ioRdata;

    // ******************************************************************
    // Memory map
    memMapDecoder uDecoder (
        .clk      (clk),
        .arstN    (arstN),
        .req      (req),
        .ramWEn   (ramWEn),
        .ramREn   (ramREn),
        .ioWEn    (ioWEn),
        .ioREn    (ioREn),
        .ramRdata (ramRdata),
        .ioRdata  (ioRdata),
        .rdata    (rdata)
    );

    // Data RAM
    dataRam uRam (
        .clk   (clk),
        .addr  (req.addr[ramAddrWidth-1:0]),
        .wdata (req.wdata),
        .wEn   (ramWEn),
        .rEn   (ramREn),
        .rdata (ramRdata)
    );

    // I/O page, low byte selects the register
    ioBlock uIo (
        .clk    (clk),
        .arstN  (arstN),
        .offset (req.addr[7:0]),
        .wdata  (req.wdata),
        .wEn    (ioWEn),
        .rEn    (ioREn),
        .rdata  (ioRdata),
        .ioPins (ioPins),
        .pwm    (pwm),
        .irq    (irq)
    );

endmodule

`default_nettype wire

/* design/timerCore.sv */
`timescale 1ns/1ps
`default_nettype none

module timerCore (
    input  wire logic                          clk,
    input  wire logic                          arstN,
    input  wire socPkg::timerCtrlT             ctrl,
    input  wire logic [socPkg::dataWidth-1:0]  top,
    input  wire logic                          loadEn,
    input  wire logic [socPkg::dataWidth-1:0]  loadValue,
    output logic [socPkg::dataWidth-1:0]       count,
    output logic                               tick,
    output logic                               topHit
);
    import socPkg::*;

    logic [2:0] preCount;   // Same width as ctrl.prescale

    // ******************************************************************
    // Tick and wrap pulses
    // A load takes the cycle, so no tick then
    assign tick   = ctrl.enable && !loadEn && (preCount == ctrl.prescale);
    assign topHit = tick && (count >= top);     // >= pulls a loaded count back in range

    // Prescaler
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            preCount <= '0;
        end else if (loadEn || !ctrl.enable || tick) begin
            preCount <= '0;
        end else begin
            preCount <= preCount + 3'd1;
        end
    end

    // ******************************************************************
    // Main counter
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            count <= '0;
        end else if (loadEn) begin
            count <= loadValue;
        end else if (topHit) begin
            count <= '0;
        end else if (tick) begin
            count <= count + dataWidth'(1);
        end
    end

    // After any tick the count is back within top, unless top was rewritten
    countInRange: assert property (@(posedge clk) disable iff (!arstN)
        tick |=> (count <= top) || !$stable(top))
        else $error("Timer count above top after a tick");

endmodule

`default_nettype wire

/* flist.f */
design/socPkg.sv
design/memMapDecoder.sv
design/dataRam.sv
design/timerCore.sv
design/matchUnit.sv
design/irqCollector.sv
design/ioBlock.sv
design/socTop.sv
tb/socTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root

set -u

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
simName=socSim

verilator --binary --timing --assert \
    -f flist.f \
    --top-module socTb \
    --Mdir "$buildDir" \
    -o "$simName"
buildStatus=$?
if [ "$buildStatus" -ne 0 ]; then
    echo "Verilator build failed with status $buildStatus" >&2
    exit "$buildStatus"
fi

"./$buildDir/$simName"
simStatus=$?
if [ "$simStatus" -ne 0 ]; then
    echo "Simulation exited with status $simStatus" >&2
    exit "$simStatus"
fi

exit 0

/* tb/busStim.txt */
# op addr value cycles: W write, R read and compare, P ioPins, Q irq, D wait
# addr and value in hex, cycles in decimal
# RAM across the region, last byte included
W 0000 a5 0
W 0001 5a 0
W 0400 3c 0
W 07fe 81 0
W 07ff e7 0
R 0000 a5 0
R 0001 5a 0
R 0400 3c 0
R 07fe 81 0
R 07ff e7 0
# Unmapped space and video window
W 0800 c3 0
W 2100 ff 0
R 0000 a5 0
R 0800 00 0
R 0fff 00 0
R 2000 00 0
R 2100 00 0
R 2960 00 0
R 3000 00 0
# GPIO
W 1000 96 0
P 0000 96 0
R 1000 96 0
# Timer registers while stopped
W 1003 55 0
R 1003 55 0
W 1002 09 0
R 1002 09 0
W 1006 03 0
W 1007 06 0
R 1006 03 0
R 1007 06 0
# Top 9, prescale 1, all flags enabled
W 1005 07 0
W 1001 90 0
R 1001 90 0
D 0000 00 48
R 1004 07 0
Q 0000 01 0
# Mask off, flags stay set
W 1005 00 0
Q 0000 00 0
R 1004 07 0
W 1005 07 0
Q 0000 01 0
# Stop the timer, then clear all flags
W 1001 00 0
W 1004 07 0
R 1004 00 0
Q 0000 00 0

/* tb/socTb.sv */
`timescale 1ns/1ps
`default_nettype none

module socTb;
    import socPkg::*;

    localparam int clkPeriod    = 20;
    localparam int resetCycles  = 4;
    localparam int sweepLen     = 96;     // Random RAM writes, then as many reads
    localparam int pwmWait      = 48;     // More than two timer periods at top 9, prescale 1
    localparam int marginCycles = 100;
    localparam string stimPath  = "tb/busStim.txt";

    logic                 clk;
    logic                 arstN;
    busReqT               req;
    logic [dataWidth-1:0] rdata;
    logic [dataWidth-1:0] ioPins;
    logic [numMatch-1:0]  pwm;
    logic                 irq;

    // Stimulus lines, one entry per operation
    byte         opQ[$];
    logic [15:0] addrQ[$];
    logic [7:0]  valueQ[$];
    int          cyclesQ[$];

    logic [31:0]             lfsrState;
    logic [dataWidth-1:0]    ramModel [ramDepth];
    logic [ramAddrWidth-1:0] sweepAddr [sweepLen];
    int                      limitCycles;
    logic                    limitReady;

    socTop u_dut (
        .clk    (clk),
        .arstN  (arstN),
        .req    (req),
        .rdata  (rdata),
        .ioPins (ioPins),
        .pwm    (pwm),
        .irq    (irq)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // **********************************************************************
    // Checking and random data
    task automatic checkValue(input string name, input logic [15:0] got,
                              input logic [15:0] expected);
        if (got !== expected) begin
            $display("FAIL time %0t: %s is %0h, expected %0h", $time, name, got, expected);
            $display("Regression failed");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic randomBits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);    // One step per bit
            v = {v[14:0], lfsrState[0]};
        end
    endtask

    // **********************************************************************
    // Bus operations
    task automatic issueReq(input busReqT r);
        @(posedge clk);
        req <= r;
        @(posedge clk);     // DUT samples the request here
        req <= '0;
    endtask

    task automatic busWrite(input logic [15:0] addr, input logic [7:0] data);
        issueReq('{addr: addr, wdata: data, wEn: 1'b1, rEn: 1'b0});
    endtask

    task automatic busRead(input logic [15:0] addr, input logic [7:0] expected);
        issueReq('{addr: addr, wdata: 8'h00, wEn: 1'b0, rEn: 1'b1});
        @(posedge clk);     // Data lands one cycle after the strobe
        @(negedge clk);
        checkValue($sformatf("rdata @%h", addr), 16'(rdata), 16'(expected));
    endtask

    // **********************************************************************
    // Stimulus file
    task automatic loadStim();
        int          fd;
        int          fields;
        int          sumWait;
        string       line;
        byte         op;
        logic [15:0] addr;
        logic [7:0]  value;
        int          cycles;
        sumWait = 0;
        fd = $fopen(stimPath, "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file %s", stimPath);
            $display("Regression failed");
            $fatal(1, "Missing stimulus file");
        end
        while ($fgets(line, fd) != 0) begin
            fields = $sscanf(line, "%c %h %h %d", op, addr, value, cycles);
            if (fields == 4 && op != "#") begin     // Skips comments and blank lines
                opQ.push_back(op);
                addrQ.push_back(addr);
                valueQ.push_back(value);
                cyclesQ.push_back(cycles);
                sumWait += cycles;
            end
        end
        $fclose(fd);
        // Worst line takes 3 cycles, a sweep entry 5
        limitCycles = resetCycles + 3 * opQ.size() + sumWait + 5 * sweepLen
                      + pwmWait + 3 * 4 + marginCycles;
        limitReady = 1'b1;
    endtask

    task automatic runStim();
        for (int i = 0; i < opQ.size(); i++) begin
            case (opQ[i])
                "W": busWrite(addrQ[i], valueQ[i]);
                "R": busRead(addrQ[i], valueQ[i]);
                "P": begin
                    @(negedge clk);
                    checkValue("ioPins", 16'(ioPins), 16'(valueQ[i]));
                end
                "Q": begin
                    @(negedge clk);
                    checkValue("irq", 16'(irq), 16'(valueQ[i][0]));
                end
                "D": repeat (cyclesQ[i]) @(posedge clk);
                default: begin
                    $display("Unknown operation on stimulus line %0d", i);
                    $display("Regression failed");
                    $fatal(1, "Bad stimulus");
                end
            endcase
        end
    endtask

    // Compares out of reach, so every wrap sets pwm and nothing clears it
    task automatic pwmHigh();
        busWrite(ioBase + 16'(regMatchBase), 8'hff);
        busWrite(ioBase + 16'(regMatchBase) + 16'd1, 8'hff);
        busWrite(ioBase + 16'(regTimerCtrl), 8'h90);
        repeat (pwmWait) @(posedge clk);
        @(negedge clk);
        checkValue("pwm", 16'(pwm), 16'({numMatch{1'b1}}));
        busWrite(ioBase + 16'(regTimerCtrl), 8'h00);
        @(negedge clk);
        checkValue("pwm", 16'(pwm), 16'({numMatch{1'b1}}));
    endtask

    // Random RAM bytes, model keeps the last write per address
    task automatic ramSweep();
        logic [15:0] bits;
        for (int i = 0; i < sweepLen; i++) begin
            randomBits(ramAddrWidth, bits);
            sweepAddr[i] = bits[ramAddrWidth-1:0];
            randomBits(dataWidth, bits);
            ramModel[sweepAddr[i]] = bits[7:0];
            busWrite(addrWidth'(sweepAddr[i]), bits[7:0]);
        end
        for (int i = 0; i < sweepLen; i++) begin
            busRead(addrWidth'(sweepAddr[i]), ramModel[sweepAddr[i]]);
        end
    endtask

    // **********************************************************************
    // Main sequence
    initial begin
        arstN      = 1'b0;
        req        = '0;
        lfsrState  = 32'hf18c;
        limitReady = 1'b0;
        loadStim();
        repeat (resetCycles) @(posedge clk);
        arstN <= 1'b1;
        @(negedge clk);
        checkValue("rdata", 16'(rdata), 16'h0);     // Reset state
        checkValue("ioPins", 16'(ioPins), 16'h0);
        checkValue("pwm", 16'(pwm), 16'h0);
        checkValue("irq", 16'(irq), 16'h0);
        runStim();
        pwmHigh();
        ramSweep();
        @(posedge clk);
        $display("Regression passed");
        $finish;
    end

    // Watchdog
    initial begin
        wait (limitReady);
        #(limitCycles * clkPeriod);
        $display("Timeout: the tests did not finish within %0d cycles", limitCycles);
        $display("Regression failed");
        $fatal(1, "Simulation hung");
    end

endmodule

`default_nettype wire
